/* design/vga_pkg.sv */
// 640x480 at 60 Hz timing only, pixel clock near 25 MHz.
// other modes would need new constants here.
`default_nettype none

package vga_pkg;

    // horizontal timing in pixels
    localparam int h_display = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = 800;

    // vertical timing in lines
    localparam int v_display = 480;
    localparam int v_bottom  = 10;
    localparam int v_sync    = 2;
    localparam int v_top     = 33;
    localparam int v_total   = 525;

    // beam counter widths
    localparam int hpos_w = 10;
    localparam int vpos_w = 10;

endpackage

`default_nettype wire

/* design/draw_pkg.sv */
// drawing command fields and 80x60 frame-buffer geometry.
// each cell covers 8x8 screen pixels.
`default_nettype none

package draw_pkg;

    // command opcodes
    typedef enum logic [1:0] {
        op_plot,
        op_hline,
        op_vline,
        op_clear
    } draw_op_e;

    // command field widths
    localparam int cell_x_w = 7;
    localparam int cell_y_w = 6;
    // line length in cells, 0 is taken as 1
    localparam int len_w    = 7;
    localparam int colour_w = 3;

    // frame-buffer geometry
    localparam int fb_cols    = 80;
    localparam int fb_rows    = 60;
    localparam int fb_cells   = 4800;
    localparam int addr_w     = 13;
    localparam int cell_shift = 3;

    // white after reset
    localparam logic [colour_w-1:0] reset_colour = 3'b111;

    localparam int fifo_depth = 8;

endpackage

`default_nettype wire

/* design/vga_timing.sv */
// free-running beam counters, syncs active low.
// outputs are decoded from the counters and not registered.
`default_nettype none

module vga_timing
    import vga_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    output logic [hpos_w-1:0] hpos,
    output logic [vpos_w-1:0] vpos,
    output logic              display_on,
    output logic              hsync_raw,
    output logic              vsync_raw
);

    logic h_last;
    logic v_last;

    // last pixel of a line, last line of a frame
    assign h_last = (hpos == hpos_w'(h_total - 1));
    assign v_last = (vpos == vpos_w'(v_total - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hpos <= '0;
            vpos <= '0;
        end else if (h_last) begin
            hpos <= '0;
            // line done, step the frame counter
            if (v_last) begin
                vpos <= '0;
            end else begin
                vpos <= vpos + 1'b1;
            end
        end else begin
            hpos <= hpos + 1'b1;
        end
    end

    // visible area is the top left corner of the raster
    assign display_on = (hpos < hpos_w'(h_display)) && (vpos < vpos_w'(v_display));

    // sync pulse sits after display and front porch
    assign hsync_raw = !((hpos >= hpos_w'(h_display + h_front))
                      && (hpos < hpos_w'(h_display + h_front + h_sync)));

    // bottom border plays the front porch role vertically
    assign vsync_raw = !((vpos >= vpos_w'(v_display + v_bottom))
                      && (vpos < vpos_w'(v_display + v_bottom + v_sync)));

    // counters must never leave the raster
    a_beam_in_raster: assert property (
        @(posedge clk) disable iff (!arst_n)
        (hpos < hpos_w'(h_total)) && (vpos < vpos_w'(v_total))
    );

endmodule

`default_nettype wire

/* design/draw_fifo.sv */
// eight-entry command queue, head shown combinationally.
// push while full and pop while empty are ignored and flagged.
`default_nettype none

module draw_fifo
    import draw_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                push,
    input  logic                pop,
    input  draw_op_e            in_op,
    input  logic [cell_x_w-1:0] in_x,
    input  logic [cell_y_w-1:0] in_y,
    input  logic [len_w-1:0]    in_len,
    input  logic [colour_w-1:0] in_colour,
    output draw_op_e            q_op,
    output logic [cell_x_w-1:0] q_x,
    output logic [cell_y_w-1:0] q_y,
    output logic [len_w-1:0]    q_len,
    output logic [colour_w-1:0] q_colour,
    output logic                full,
    output logic                empty
);

    // storage, one array per field
    draw_op_e            mem_op     [fifo_depth];
    logic [cell_x_w-1:0] mem_x      [fifo_depth];
    logic [cell_y_w-1:0] mem_y      [fifo_depth];
    logic [len_w-1:0]    mem_len    [fifo_depth];
    logic [colour_w-1:0] mem_colour [fifo_depth];

    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic [$clog2(fifo_depth):0]   count;
    logic                          do_wr;
    logic                          do_rd;

    assign do_wr = push && !full;
    assign do_rd = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_op[wr_ptr]     <= in_op;
            mem_x[wr_ptr]      <= in_x;
            mem_y[wr_ptr]      <= in_y;
            mem_len[wr_ptr]    <= in_len;
            mem_colour[wr_ptr] <= in_colour;
        end
    end

    // pointers wrap on their own at depth 8
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy holds when both happen
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full  = (count == fifo_depth);
    assign empty = (count == '0);

    // head of queue
    assign q_op     = mem_op[rd_ptr];
    assign q_x      = mem_x[rd_ptr];
    assign q_y      = mem_y[rd_ptr];
    assign q_len    = mem_len[rd_ptr];
    assign q_colour = mem_colour[rd_ptr];

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) !(push && full)
    );
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n) !(pop && empty)
    );

endmodule

`default_nettype wire

/* design/draw_decode.sv */
// turns the queue head into one run of cell writes.
// out-of-range commands other than clear are dropped silently.
`default_nettype none

module draw_decode
    import draw_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                q_empty,
    input  logic                run_ready,
    input  draw_op_e            q_op,
    input  logic [cell_x_w-1:0] q_x,
    input  logic [cell_y_w-1:0] q_y,
    input  logic [len_w-1:0]    q_len,
    input  logic [colour_w-1:0] q_colour,
    output logic                pop,
    output logic                run_start,
    output logic [addr_w-1:0]   run_addr,
    output logic [addr_w-1:0]   run_count,
    output logic [addr_w-1:0]   run_stride,
    output logic [colour_w-1:0] run_colour
);

    logic                in_range;
    logic [addr_w-1:0]   len_eff;
    logic [addr_w-1:0]   row_room;
    logic [addr_w-1:0]   col_room;
    logic [addr_w-1:0]   next_addr;
    logic [addr_w-1:0]   next_count;
    logic [addr_w-1:0]   next_stride;

    // hold off while a strobe is still on its way to execute
    assign pop = !q_empty && run_ready && !run_start;

    assign in_range = (q_op == op_clear)
                   || ((q_x < cell_x_w'(fb_cols)) && (q_y < cell_y_w'(fb_rows)));

    // zero length means a single cell
    assign len_eff  = (q_len == '0) ? addr_w'(1) : addr_w'(q_len);
    // cells left to the row end and column end
    assign row_room = addr_w'(fb_cols) - addr_w'(q_x);
    assign col_room = addr_w'(fb_rows) - addr_w'(q_y);

    always_comb begin
        // row-major start cell
        next_addr   = addr_w'(q_y) * addr_w'(fb_cols) + addr_w'(q_x);
        next_count  = addr_w'(1);
        next_stride = addr_w'(1);
        unique case (q_op)
            op_plot: begin
                next_count = addr_w'(1);
            end
            op_hline: begin
                next_count = (len_eff > row_room) ? row_room : len_eff;
            end
            op_vline: begin
                next_count  = (len_eff > col_room) ? col_room : len_eff;
                next_stride = addr_w'(fb_cols);
            end
            op_clear: begin
                next_addr  = '0;
                next_count = addr_w'(fb_cells);
            end
        endcase
    end

    // strobe lasts one cycle, only for a good command
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_start <= 1'b0;
        end else begin
            run_start <= pop && in_range;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            run_addr   <= next_addr;
            run_count  <= next_count;
            run_stride <= next_stride;
            run_colour <= q_colour;
        end
    end

endmodule

`default_nettype wire

/* design/draw_execute.sv */
// writes one cell per blanking cycle, runs pause during display.
// the reset fill reuses the run datapath with white over all cells.
`default_nettype none

module draw_execute
    import draw_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                display_on,
    input  logic                run_start,
    input  logic [addr_w-1:0]   run_addr,
    input  logic [addr_w-1:0]   run_count,
    input  logic [addr_w-1:0]   run_stride,
    input  logic [colour_w-1:0] run_colour,
    output logic                run_ready,
    output logic                wr_en,
    output logic [addr_w-1:0]   wr_addr,
    output logic [colour_w-1:0] wr_colour
);

    typedef enum logic [1:0] {
        s_fill,
        s_idle,
        s_run
    } state_e;

    state_e              state;
    logic [addr_w-1:0]   addr;
    logic [addr_w-1:0]   remaining;
    logic [addr_w-1:0]   stride;
    logic [colour_w-1:0] colour;
    logic                step;

    // one cell per cycle, blanking only
    assign step      = (state != s_idle) && !display_on;
    assign run_ready = (state == s_idle);

    assign wr_en     = step;
    assign wr_addr   = addr;
    assign wr_colour = colour;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // fill set up as a run over the whole buffer
            state     <= s_fill;
            addr      <= '0;
            remaining <= addr_w'(fb_cells);
            stride    <= addr_w'(1);
            colour    <= reset_colour;
        end else begin
            case (state)
                s_idle: begin
                    if (run_start) begin
                        state     <= s_run;
                        addr      <= run_addr;
                        remaining <= run_count;
                        stride    <= run_stride;
                        colour    <= run_colour;
                    end
                end
                default: begin
                    // fill and run step alike
                    if (step) begin
                        addr      <= addr + stride;
                        remaining <= remaining - 1'b1;
                        if (remaining == addr_w'(1)) begin
                            state <= s_idle;
                        end
                    end
                end
            endcase
        end
    end

    // stepping by the stride never leaves the buffer
    a_write_in_buffer: assert property (
        @(posedge clk) disable iff (!arst_n) wr_en |-> (wr_addr < addr_w'(fb_cells))
    );

    // decode only strobes while we are idle
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n) run_start |-> (state == s_idle)
    );

endmodule

`default_nettype wire

/* design/frame_result.sv */
// 4800x3 frame buffer with registered scan-out.
// rgb and syncs lag the beam counters by exactly one cycle.
`default_nettype none

module frame_result
    import vga_pkg::*;
    import draw_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                display_on,
    input  logic                hsync_raw,
    input  logic                vsync_raw,
    input  logic                wr_en,
    input  logic [hpos_w-1:0]   hpos,
    input  logic [vpos_w-1:0]   vpos,
    input  logic [addr_w-1:0]   wr_addr,
    input  logic [colour_w-1:0] wr_colour,
    output logic                hsync,
    output logic                vsync,
    output logic [colour_w-1:0] rgb
);

    logic [colour_w-1:0] fb_mem [fb_cells];
    logic [addr_w-1:0]   rd_addr;
    logic [addr_w-1:0]   cell_col;
    logic [addr_w-1:0]   cell_row;

    // beam position to cell, 8 pixels per cell
    assign cell_col = addr_w'(hpos >> cell_shift);
    assign cell_row = addr_w'(vpos >> cell_shift);
    assign rd_addr  = cell_row * addr_w'(fb_cols) + cell_col;

    // write port, driven only in blanking
    always_ff @(posedge clk) begin
        if (wr_en) begin
            fb_mem[wr_addr] <= wr_colour;
        end
    end

    // read and sync delay share one register stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            rgb   <= '0;
        end else begin
            hsync <= hsync_raw;
            vsync <= vsync_raw;
            // black outside the visible area
            if (display_on) begin
                rgb <= fb_mem[rd_addr];
            end else begin
                rgb <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/fb_draw_top.sv */
// command queue, decode, execute and scan-out for an 80x60 cell display.
// a push is lost when cmd_full is high.
`default_nettype none

module fb_draw_top
    import vga_pkg::*;
    import draw_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cmd_push,
    input  draw_op_e            cmd_op,
    input  logic [cell_x_w-1:0] cmd_x,
    input  logic [cell_y_w-1:0] cmd_y,
    input  logic [len_w-1:0]    cmd_len,
    input  logic [colour_w-1:0] cmd_colour,
    output logic                cmd_full,
    output logic                busy,
    output logic                hsync,
    output logic                vsync,
    output logic [colour_w-1:0] rgb
);

    // beam
    logic [hpos_w-1:0]   hpos;
    logic [vpos_w-1:0]   vpos;
    logic                display_on;
    logic                hsync_raw;
    logic                vsync_raw;

    // queue head
    draw_op_e            q_op;
    logic [cell_x_w-1:0] q_x;
    logic [cell_y_w-1:0] q_y;
    logic [len_w-1:0]    q_len;
    logic [colour_w-1:0] q_colour;
    logic                q_empty;
    logic                pop;

    // run handoff and write port
    logic                run_start;
    logic                run_ready;
    logic [addr_w-1:0]   run_addr;
    logic [addr_w-1:0]   run_count;
    logic [addr_w-1:0]   run_stride;
    logic [colour_w-1:0] run_colour;
    logic                wr_en;
    logic [addr_w-1:0]   wr_addr;
    logic [colour_w-1:0] wr_colour;

    // queued work, a strobe in flight, or a fill or run in progress
    assign busy = !q_empty || run_start || !run_ready;

    vga_timing timing_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .hpos       (hpos),
        .vpos       (vpos),
        .display_on (display_on),
        .hsync_raw  (hsync_raw),
        .vsync_raw  (vsync_raw)
    );

    draw_fifo fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (cmd_push),
        .pop       (pop),
        .in_op     (cmd_op),
        .in_x      (cmd_x),
        .in_y      (cmd_y),
        .in_len    (cmd_len),
        .in_colour (cmd_colour),
        .q_op      (q_op),
        .q_x       (q_x),
        .q_y       (q_y),
        .q_len     (q_len),
        .q_colour  (q_colour),
        .full      (cmd_full),
        .empty     (q_empty)
    );

    draw_decode decode_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .q_empty    (q_empty),
        .run_ready  (run_ready),
        .q_op       (q_op),
        .q_x        (q_x),
        .q_y        (q_y),
        .q_len      (q_len),
        .q_colour   (q_colour),
        .pop        (pop),
        .run_start  (run_start),
        .run_addr   (run_addr),
        .run_count  (run_count),
        .run_stride (run_stride),
        .run_colour (run_colour)
    );

    draw_execute execute_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .display_on (display_on),
        .run_start  (run_start),
        .run_addr   (run_addr),
        .run_count  (run_count),
        .run_stride (run_stride),
        .run_colour (run_colour),
        .run_ready  (run_ready),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_colour  (wr_colour)
    );

    frame_result result_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .display_on (display_on),
        .hsync_raw  (hsync_raw),
        .vsync_raw  (vsync_raw),
        .wr_en      (wr_en),
        .hpos       (hpos),
        .vpos       (vpos),
        .wr_addr    (wr_addr),
        .wr_colour  (wr_colour),
        .hsync      (hsync),
        .vsync      (vsync),
        .rgb        (rgb)
    );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
// free-running testbench clock, period 100 time units.
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam int half_period = 50;

    // first rising edge at 50
    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* tests/fb_draw_tb.sv */
// checks run on falling clock edges, inputs change 10 units after rising edges.
// pixel checks are skipped while busy is high, since the buffer is in motion then.
`default_nettype none

module fb_draw_tb
    import vga_pkg::*;
    import draw_pkg::*;
();

    localparam longint clk_period = 100;
    localparam longint frame_time = longint'(h_total) * v_total * clk_period;
    localparam longint watchdog_time = 12 * frame_time;

    logic                clk;
    logic                arst_n;
    logic                cmd_push;
    draw_op_e            cmd_op;
    logic [cell_x_w-1:0] cmd_x;
    logic [cell_y_w-1:0] cmd_y;
    logic [len_w-1:0]    cmd_len;
    logic [colour_w-1:0] cmd_colour;
    logic                cmd_full;
    logic                busy;
    logic                hsync;
    logic                vsync;
    logic [colour_w-1:0] rgb;

    // expected buffer contents
    logic [2:0]  model [fb_cells];
    logic [31:0] rng_state;
    int          errors;
    int          pixels_checked;
    // beam as seen on the outputs
    int          px;
    int          ln;
    logic        h_locked;
    logic        v_locked;
    logic        prev_hsync;
    logic        prev_vsync;
    int          cycle;
    int          last_hfall;
    int          last_vfall;
    int          r;

    tb_clock clock_i (
        .clk (clk)
    );

    fb_draw_top dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_push   (cmd_push),
        .cmd_op     (cmd_op),
        .cmd_x      (cmd_x),
        .cmd_y      (cmd_y),
        .cmd_len    (cmd_len),
        .cmd_colour (cmd_colour),
        .cmd_full   (cmd_full),
        .busy       (busy),
        .hsync      (hsync),
        .vsync      (vsync),
        .rgb        (rgb)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic flag_mismatch(input string sig, input int got, input int exp);
        errors++;
        $display("ERROR %s: got %h expected %h", sig, got, exp);
    endtask

    // buffer update straight from the command rules
    task automatic apply_model(input draw_op_e op, input int x, input int y,
                               input int len, input logic [2:0] colour);
        int n;
        int i;
        n = (len == 0) ? 1 : len;
        if (op == op_clear) begin
            for (i = 0; i < 4800; i++) begin
                model[i] = colour;
            end
        end else if (x < 80 && y < 60) begin
            case (op)
                op_plot: begin
                    model[y * 80 + x] = colour;
                end
                op_hline: begin
                    for (i = 0; i < n && x + i < 80; i++) begin
                        model[y * 80 + x + i] = colour;
                    end
                end
                op_vline: begin
                    for (i = 0; i < n && y + i < 60; i++) begin
                        model[(y + i) * 80 + x] = colour;
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    // called 10 after a rising edge, returns 10 after the taking edge
    task automatic push_cmd(input draw_op_e op, input int x, input int y,
                            input int len, input logic [2:0] colour);
        while (cmd_full) begin
            @(posedge clk);
            #10;
        end
        cmd_op     = op;
        cmd_x      = cell_x_w'(x);
        cmd_y      = cell_y_w'(y);
        cmd_len    = len_w'(len);
        cmd_colour = colour;
        cmd_push   = 1'b1;
        @(posedge clk);
        #10;
        cmd_push = 1'b0;
        apply_model(op, x, y, len, colour);
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #10;
        end
    endtask

    // a whole visible frame lies between two vsync falls
    task automatic wait_frame();
        @(negedge vsync);
        @(negedge vsync);
        @(posedge clk);
        #10;
    endtask

    always @(negedge clk) begin
        if ($time == 0) begin
            // clock start, the reset has not reached the outputs yet
        end else if (!arst_n) begin
            assert (hsync === 1'b1) else flag_mismatch("hsync", hsync, 1);
            assert (vsync === 1'b1) else flag_mismatch("vsync", vsync, 1);
            assert (rgb === 3'b000) else flag_mismatch("rgb", rgb, 0);
            assert (cmd_full === 1'b0) else flag_mismatch("cmd_full", cmd_full, 0);
            assert (busy === 1'b1) else flag_mismatch("busy", busy, 1);
        end else begin
            cycle++;
            // step the beam, wrap at line and frame end
            if (h_locked) begin
                if (px == h_total - 1) begin
                    px = 0;
                    ln = (ln == v_total - 1) ? 0 : ln + 1;
                end else begin
                    px = px + 1;
                end
            end
            if (!hsync && prev_hsync) begin
                if (h_locked) begin
                    assert (cycle - last_hfall == h_total)
                        else flag_mismatch("hsync period", cycle - last_hfall, h_total);
                end
                px = h_display + h_front;
                h_locked = 1'b1;
                last_hfall = cycle;
            end
            if (!vsync && prev_vsync) begin
                if (v_locked) begin
                    assert (cycle - last_vfall == h_total * v_total)
                        else flag_mismatch("vsync period", cycle - last_vfall, h_total * v_total);
                end
                if (h_locked) begin
                    assert (px == 0) else flag_mismatch("vsync fall pixel", px, 0);
                end
                ln = v_display + v_bottom;
                v_locked = 1'b1;
                last_vfall = cycle;
            end
            // sync widths measured at the rising edge
            if (hsync && !prev_hsync && h_locked) begin
                assert (cycle - last_hfall == h_sync)
                    else flag_mismatch("hsync low width", cycle - last_hfall, h_sync);
            end
            if (vsync && !prev_vsync && v_locked) begin
                assert (cycle - last_vfall == v_sync * h_total)
                    else flag_mismatch("vsync low width", cycle - last_vfall, v_sync * h_total);
            end
            if (h_locked && v_locked) begin
                if (px >= h_display || ln >= v_display) begin
                    assert (rgb == 3'b000) else flag_mismatch("rgb in blanking", rgb, 0);
                end else if (!busy) begin
                    pixels_checked++;
                    assert (rgb == model[(ln / 8) * 80 + px / 8])
                        else flag_mismatch($sformatf("rgb at %0d,%0d", px, ln), rgb,
                                           model[(ln / 8) * 80 + px / 8]);
                end
            end
        end
        prev_hsync = hsync;
        prev_vsync = vsync;
    end

    initial begin
        arst_n     = 1'b0;
        cmd_push   = 1'b0;
        cmd_op     = op_plot;
        cmd_x      = '0;
        cmd_y      = '0;
        cmd_len    = '0;
        cmd_colour = '0;
        errors         = 0;
        pixels_checked = 0;
        px         = 0;
        ln         = 0;
        h_locked   = 1'b0;
        v_locked   = 1'b0;
        prev_hsync = 1'b1;
        prev_vsync = 1'b1;
        cycle      = 0;
        last_hfall = 0;
        last_vfall = 0;
        rng_state  = 32'h82d0;
        // buffer is white after the reset fill
        for (int i = 0; i < 4800; i++) begin
            model[i] = 3'b111;
        end
        repeat (5) @(posedge clk);
        #10;
        arst_n = 1'b1;

        // reset fill, then one white frame
        wait_idle();
        wait_frame();

        // random plots, one at a time
        for (int i = 0; i < 20; i++) begin
            rng_state = next_random(rng_state);
            r = int'(rng_state[30:0]);
            push_cmd(op_plot, r % 80, (r >> 8) % 60, 0, rng_state[18:16]);
            wait_idle();
        end
        wait_frame();

        // clipping at the edges, zero length, dropped commands
        push_cmd(op_hline, 74, 10, 20, 3'b011);
        push_cmd(op_hline, 0, 0, 0, 3'b010);
        push_cmd(op_vline, 5, 50, 30, 3'b101);
        push_cmd(op_vline, 79, 0, 127, 3'b001);
        push_cmd(op_plot, 80, 3, 0, 3'b000);
        push_cmd(op_hline, 10, 60, 5, 3'b000);
        push_cmd(op_vline, 100, 20, 4, 3'b000);
        wait_idle();
        wait_frame();

        // clear, then nine plots back to back against a full queue
        push_cmd(op_clear, 0, 0, 0, 3'b100);
        for (int i = 0; i < 9; i++) begin
            rng_state = next_random(rng_state);
            r = int'(rng_state[30:0]);
            push_cmd(op_plot, r % 80, (r >> 8) % 60, 0, rng_state[18:16]);
            if (i < 8) begin
                assert (cmd_full == (i == 7)) else flag_mismatch("cmd_full", cmd_full, i == 7);
            end
        end
        wait_idle();
        wait_frame();

        if (pixels_checked == 0) begin
            errors++;
            $display("no displayed pixel was compared against the model");
        end
        $display("errors: %0d, pixels checked: %0d", errors, pixels_checked);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // twelve frame times covers every wait above
    initial begin
        #watchdog_time;
        $display("timeout: the run did not finish within twelve frame times");
        $display("errors: %0d, pixels checked: %0d", errors, pixels_checked);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
design/vga_pkg.sv
design/draw_pkg.sv
design/vga_timing.sv
design/draw_fifo.sv
design/draw_decode.sv
design/draw_execute.sv
design/frame_result.sv
design/fb_draw_top.sv
tests/tb_clock.sv
tests/fb_draw_tb.sv

/* Bender.yml */
package:
  name: fb_draw

sources:
  - design/vga_pkg.sv
  - design/draw_pkg.sv
  - design/vga_timing.sv
  - design/draw_fifo.sv
  - design/draw_decode.sv
  - design/draw_execute.sv
  - design/frame_result.sv
  - design/fb_draw_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/fb_draw_tb.sv
